/* sim.f */
+incdir+logic
logic/chan_io_pkg.sv
logic/ipb_io_interface.sv
logic/chan_regs.sv
logic/chan_bus_arbiter.sv
logic/all_channels.sv
verification/all_channels_assertions.sv
verification/all_channels_tb.sv

/* Bender.yml */
package:
  name: all_channels

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/chan_io_pkg.sv
      - logic/ipb_io_interface.sv
      - logic/chan_regs.sv
      - logic/chan_bus_arbiter.sv
      - logic/all_channels.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/all_channels_assertions.sv
      - verification/all_channels_tb.sv

/* verification/all_channels_tb.sv */
// testbench for the IPbus channel register side
// seeded random single reads and writes checked against a register model
`timescale 1ns/10ps
`default_nettype none

`include "chan_io_params.svh"

module all_channels_tb;

  import chan_io_pkg::*;

  localparam int BUS_TIMEOUT = `RD_TIMEOUT + 8;     // cycles a bus access may take
  localparam int NUM_OPS     = 400;

  // one debug flag per watched FSM state
  localparam logic [3:0] DBG_IDLE  = 4'b0001;
  localparam logic [3:0] DBG_START = 4'b0010;
  localparam logic [3:0] DBG_WAIT  = 4'b0100;
  localparam logic [3:0] DBG_ACK   = 4'b1000;

  logic                   ipb_clk;
  logic                   arst_n;
  logic                   ipb_strobe;
  logic [`IPB_ADDR_W-1:0] ipb_addr;
  logic                   ipb_write;
  logic [`IPB_DATA_W-1:0] ipb_wdata;
  logic [`IPB_DATA_W-1:0] ipb_rdata;
  logic                   ipb_ack;
  logic                   ipb_err;
  logic [`NUM_CHAN-1:0]   chan_enable;
  logic [3:0]             debug;

  // register model, one entry per channel
  logic [`IPB_DATA_W-1:0] ctrl_m    [`NUM_CHAN];
  logic [`IPB_DATA_W-1:0] scratch_m [`NUM_CHAN];
  logic [`IPB_DATA_W-1:0] fifo_m    [`NUM_CHAN][$];

  integer seed;
  int     mismatches;
  int     timeouts;

  initial ipb_clk = 1'b0;
  always #2 ipb_clk = ~ipb_clk;                     // 4 ns period

  all_channels dut_i (
    .ipb_clk     (ipb_clk),
    .arst_n      (arst_n),
    .ipb_strobe  (ipb_strobe),
    .ipb_addr    (ipb_addr),
    .ipb_write   (ipb_write),
    .ipb_wdata   (ipb_wdata),
    .ipb_rdata   (ipb_rdata),
    .ipb_ack     (ipb_ack),
    .ipb_err     (ipb_err),
    .chan_enable (chan_enable),
    .debug       (debug)
  );

  ////////////////////
  // compare tasks
  task automatic check_data(input logic [`IPB_DATA_W-1:0] got,
                            input logic [`IPB_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic got_ack, input logic got_err,
                            input logic exp_err, input string what);
    if (got_ack !== ~exp_err || got_err !== exp_err) begin
      mismatches++;
      $display("Mismatch at %0t: %s answered ack=%b err=%b, expected %s",
               $time, what, got_ack, got_err, exp_err ? "err" : "ack");
    end
  endtask

  task automatic check_enable(input logic [`NUM_CHAN-1:0] got,
                              input logic [`NUM_CHAN-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: chan_enable %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_debug(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: debug %b in %s, expected %b", $time, got, what, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // one IPbus access, strobe held until ack or err seen at a rising edge
  task automatic bus_cycle(input logic wr, input logic [`IPB_ADDR_W-1:0] addr,
                           input logic [`IPB_DATA_W-1:0] wdata,
                           output logic [`IPB_DATA_W-1:0] rdata, output logic ack,
                           output logic err, output int cycles, output bit answered,
                           output logic [3:0] dbg_first, output logic [3:0] dbg_wait,
                           output logic [3:0] dbg_last);
    @(posedge ipb_clk);
    #1;
    check_debug(debug, DBG_IDLE, "idle gap");      // FSM back in IDLE between accesses
    ipb_strobe = 1'b1;
    ipb_addr   = addr;
    ipb_write  = wr;
    ipb_wdata  = wdata;
    cycles     = 0;
    answered   = 1'b0;
    rdata      = '0;
    ack        = 1'b0;
    err        = 1'b0;
    dbg_first  = '0;
    dbg_wait   = '0;
    dbg_last   = '0;
    while (!answered && cycles < BUS_TIMEOUT) begin
      @(posedge ipb_clk);
      @(negedge ipb_clk);                           // outputs settled since the edge
      cycles++;
      if (ipb_ack || ipb_err) begin
        answered = 1'b1;
        ack      = ipb_ack;
        err      = ipb_err;
        rdata    = ipb_rdata;
        dbg_last = debug;
      end else if (cycles == 1) begin
        dbg_first = debug;                          // first state after the strobe
      end else if (cycles == 2) begin
        dbg_wait = debug;
      end
    end
    if (!answered) begin
      timeouts++;
      $display("Timeout: no ipb_ack or ipb_err within %0d cycles for address %h",
               BUS_TIMEOUT, addr);
    end
    @(posedge ipb_clk);                             // master sees the answer here
    #1;
    ipb_strobe = 1'b0;
  endtask

  ////////////////////
  // model side of each access
  task automatic model_write(input int c, input logic [3:0] off,
                             input logic [`IPB_DATA_W-1:0] data);
    case (off)
      REG_CTRL:    ctrl_m[c]    = data;
      REG_SCRATCH: scratch_m[c] = data;
      REG_FIFO:    if (fifo_m[c].size() < `FIFO_DEPTH) fifo_m[c].push_back(data);
      default:     ;                                // read-only or unmapped
    endcase
  endtask

  task automatic model_read(input int c, input logic [3:0] off,
                            output logic [`IPB_DATA_W-1:0] exp);
    exp = '0;
    case (off)
      REG_CTRL:    exp = ctrl_m[c];
      REG_SCRATCH: exp = scratch_m[c];
      REG_FIFO:    if (fifo_m[c].size() != 0) exp = fifo_m[c].pop_front();
      REG_LEVEL:   exp = fifo_m[c].size();
      REG_ID:      exp = c;
      default:     exp = '0;
    endcase
  endtask

  task automatic run_op(input logic wr, input logic [3:0] chan, input logic [3:0] off,
                        input logic [`IPB_DATA_W-1:0] data, input logic [15:0] mid);
    logic [`IPB_DATA_W-1:0] rdata, exp;
    logic                   ack, err, reserved;
    logic [`NUM_CHAN-1:0]   exp_en;
    logic [3:0]             dbg_first, dbg_wait, dbg_last;
    int                     cycles;
    bit                     answered;
    string                  what;

    reserved = (int'(chan) >= `NUM_CHAN);
    what = $sformatf("%s ch %0d off %0d", wr ? "write" : "read", chan, off);
    bus_cycle(wr, {chan, mid, off}, data, rdata, ack, err, cycles, answered,
              dbg_first, dbg_wait, dbg_last);
    if (answered) begin
      check_resp(ack, err, reserved, what);
      if (reserved) begin
        check_latency(cycles, 1, what);             // model left alone
        check_debug(dbg_last, '0, what);            // ERR carries no flag
      end else if (wr) begin
        check_latency(cycles, 2, what);
        check_debug(dbg_first, '0, what);
        check_debug(dbg_last, '0, what);
        model_write(int'(chan), off, data);
      end else begin
        check_debug(dbg_first, DBG_START, what);
        if (cycles > 2) check_debug(dbg_wait, DBG_WAIT, what);
        check_debug(dbg_last, DBG_ACK, what);
        model_read(int'(chan), off, exp);
        check_data(rdata, exp, what);
      end
    end
    for (int i = 0; i < `NUM_CHAN; i++) exp_en[i] = ctrl_m[i][0];
    check_enable(chan_enable, exp_en);
  endtask

  ////////////////////
  // stimulus
  initial begin
    logic [31:0] r, d, m;
    logic [3:0]  chan, off;
    int          asrt_fails;

    seed       = 32'hef9cf98f;
    mismatches = 0;
    timeouts   = 0;
    arst_n     = 1'b0;
    ipb_strobe = 1'b0;
    ipb_addr   = '0;
    ipb_write  = 1'b0;
    ipb_wdata  = '0;
    for (int i = 0; i < `NUM_CHAN; i++) begin
      ctrl_m[i]    = '0;
      scratch_m[i] = '0;
      fifo_m[i].delete();
    end
    repeat (10) @(posedge ipb_clk);
    #1;
    arst_n = 1'b1;

    // reset values of every channel
    check_enable(chan_enable, '0);
    for (int c = 0; c < `NUM_CHAN; c++) begin
      run_op(1'b0, 4'(c), REG_CTRL, '0, '0);
      run_op(1'b0, 4'(c), REG_SCRATCH, '0, '0);
      run_op(1'b0, 4'(c), REG_LEVEL, '0, '0);
      run_op(1'b0, 4'(c), REG_ID, '0, '0);
    end

    // fifo on channel 2, empty pop, overfill, drain past empty
    run_op(1'b0, 4'd2, REG_FIFO, '0, '0);
    for (int k = 0; k < `FIFO_DEPTH + 2; k++) run_op(1'b1, 4'd2, REG_FIFO, 32'hc0de_0000 + k, '0);
    run_op(1'b0, 4'd2, REG_LEVEL, '0, '0);
    for (int k = 0; k < `FIFO_DEPTH + 1; k++) run_op(1'b0, 4'd2, REG_FIFO, '0, '0);
    run_op(1'b0, 4'd2, REG_LEVEL, '0, '0);

    // random mix, about one in eight to a reserved channel field
    for (int n = 0; n < NUM_OPS; n++) begin
      r = $random(seed);
      d = $random(seed);
      m = $random(seed);
      if (r[2:0] == 3'd0) chan = 4'(`NUM_CHAN + int'(r[7:4]) % (16 - `NUM_CHAN));
      else                chan = 4'(int'(r[11:8]) % `NUM_CHAN);
      if (r[14:12] == 3'd0) off = r[19:16];          // now and then an unmapped offset
      else                  off = 4'(int'(r[23:20]) % 5);
      run_op(r[24], chan, off, d, m[15:0]);
    end

    asrt_fails = dut_i.ipb_io_interface_i.assertions_i.fail_cnt;
    $display("mismatches %0d, timeouts %0d, assertion failures %0d",
             mismatches, timeouts, asrt_fails);
    if (mismatches == 0 && timeouts == 0 && asrt_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/all_channels_assertions.sv */
// protocol checks on the IPbus wait-state controller
// bound into every ipb_io_interface instance
`timescale 1ns/10ps
`default_nettype none

module all_channels_assertions (
  input logic ipb_clk,
  input logic arst_n,
  input logic ipb_strobe,
  input logic io_wr_en,
  input logic ipb_ack,
  input logic ipb_err
);

  int unsigned fail_cnt = 0;                        // failed assertion count, read at end of run

  ack_err_excl: assert property (@(posedge ipb_clk) disable iff (!arst_n)
    !(ipb_ack && ipb_err))
    else begin
      fail_cnt++;
      $error("ipb_ack and ipb_err high in the same cycle");
    end

  ack_one_cycle: assert property (@(posedge ipb_clk) disable iff (!arst_n)
    ipb_ack |=> !ipb_ack)
    else begin
      fail_cnt++;
      $error("ipb_ack longer than one cycle");
    end

  err_one_cycle: assert property (@(posedge ipb_clk) disable iff (!arst_n)
    ipb_err |=> !ipb_err)
    else begin
      fail_cnt++;
      $error("ipb_err longer than one cycle");
    end

  // write enable is a single pulse per write
  wr_en_pulse: assert property (@(posedge ipb_clk) disable iff (!arst_n)
    io_wr_en |=> !io_wr_en)
    else begin
      fail_cnt++;
      $error("io_wr_en longer than one cycle");
    end

  answer_after_strobe: assert property (@(posedge ipb_clk) disable iff (!arst_n)
    (ipb_ack || ipb_err) |-> $past(ipb_strobe))
    else begin
      fail_cnt++;
      $error("answer without a preceding ipb_strobe");
    end

endmodule

bind ipb_io_interface all_channels_assertions assertions_i (.*);

`default_nettype wire

/* logic/all_channels.sv */
// IPbus register side of the multi-channel serial-link board
// wait-state controller, channel decoder and one register block per channel
`timescale 1ns/10ps
`default_nettype none

`include "chan_io_params.svh"

module all_channels (
  input  logic                   ipb_clk,
  input  logic                   arst_n,
  input  logic                   ipb_strobe,
  input  logic [`IPB_ADDR_W-1:0] ipb_addr,
  input  logic                   ipb_write,
  input  logic [`IPB_DATA_W-1:0] ipb_wdata,
  output logic [`IPB_DATA_W-1:0] ipb_rdata,
  output logic                   ipb_ack,
  output logic                   ipb_err,
  output logic [`NUM_CHAN-1:0]   chan_enable,  // link enables, CTRL bit 0 of each channel
  output logic [3:0]             debug
);

  import chan_io_pkg::*;

  logic                                  io_sync, io_rd_en, io_wr_en;
  logic                                  io_rd_ack, addr_bad;
  logic [`NUM_CHAN-1:0]                  chan_sel, rd_ack_all;
  logic [`NUM_CHAN-1:0][`IPB_DATA_W-1:0] rd_data_all;
  io_state_e                             state_peek;

  ipb_io_interface ipb_io_interface_i (
    .ipb_clk, .arst_n, .ipb_strobe, .ipb_write,
    .io_rd_ack, .addr_bad,
    .io_sync, .io_rd_en, .io_wr_en,
    .ipb_ack, .ipb_err, .state_peek
  );

  chan_bus_arbiter chan_bus_arbiter_i (
    .ipb_clk, .arst_n, .ipb_addr,
    .rd_data_all, .rd_ack_all,
    .chan_sel, .addr_bad, .io_rd_ack, .ipb_rdata
  );

  ////////////////////
  // channel blocks, identity is the slot number
  for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
    chan_regs #(.CHAN_ID(i)) chan_regs_i (
      .ipb_clk, .arst_n,
      .chan_sel    (chan_sel[i]),
      .io_sync, .io_rd_en, .io_wr_en,
      .io_addr     (ipb_addr[3:0]),            // register offset
      .io_wr_data  (ipb_wdata),
      .rd_data     (rd_data_all[i]),
      .rd_ack      (rd_ack_all[i]),
      .chan_enable (chan_enable[i])
    );
  end

  assign debug[0] = (state_peek == IDLE);
  assign debug[1] = (state_peek == READ_START);
  assign debug[2] = (state_peek == READ_WAIT);
  assign debug[3] = (state_peek == READ_ACK);

endmodule

`default_nettype wire

/* logic/chan_bus_arbiter.sv */
// channel decoder and readback steering
// one-hot channel selects from the top address field, reserved field flag,
// and a registered ack with the acking channel's data for the IPbus
`timescale 1ns/10ps
`default_nettype none

`include "chan_io_params.svh"

module chan_bus_arbiter (
  input  logic                                  ipb_clk,
  input  logic                                  arst_n,
  input  logic [`IPB_ADDR_W-1:0]                ipb_addr,
  input  logic [`NUM_CHAN-1:0][`IPB_DATA_W-1:0] rd_data_all,  // one word per channel
  input  logic [`NUM_CHAN-1:0]                  rd_ack_all,
  output logic [`NUM_CHAN-1:0]                  chan_sel,
  output logic                                  addr_bad,
  output logic                                  io_rd_ack,
  output logic [`IPB_DATA_W-1:0]                ipb_rdata
);

  logic [3:0] chan_fld;                           // channel field of the address

  assign chan_fld = ipb_addr[`CHAN_SEL_LSB +: 4];

  ////////////////////
  // decode
  always_comb begin
    for (int i = 0; i < `NUM_CHAN; i++) begin
      chan_sel[i] = (chan_fld == 4'(i));
    end
  end

  assign addr_bad = (int'(chan_fld) >= `NUM_CHAN); // NUM_CHAN up to 15 reserved

  ////////////////////
  // readback steering
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      io_rd_ack <= 1'b0;
    end else begin
      io_rd_ack <= |rd_ack_all;                   // only the addressed channel acks
    end
  end

  // take the word of whichever channel acked, hold until the next ack
  always_ff @(posedge ipb_clk) begin
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (rd_ack_all[i]) ipb_rdata <= rd_data_all[i];
    end
  end

endmodule

`default_nettype wire

/* logic/chan_regs.sv */
// register block of one serial-link channel
// control and scratch words, a small loopback FIFO with its level,
// and a read-only identity word; acks each read once
`timescale 1ns/10ps
`default_nettype none

`include "chan_io_params.svh"

module chan_regs #(
  parameter int unsigned CHAN_ID = 0            // value returned at REG_ID
) (
  input  logic                   ipb_clk,
  input  logic                   arst_n,
  input  logic                   chan_sel,      // address field matches this channel
  input  logic                   io_sync,
  input  logic                   io_rd_en,
  input  logic                   io_wr_en,
  input  logic [3:0]             io_addr,       // register offset
  input  logic [`IPB_DATA_W-1:0] io_wr_data,
  output logic [`IPB_DATA_W-1:0] rd_data,
  output logic                   rd_ack,
  output logic                   chan_enable    // link enable
);

  import chan_io_pkg::*;

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  chan_reg_e              reg_op;
  logic [`IPB_DATA_W-1:0] ctrl_q, scratch_q;
  logic [`IPB_DATA_W-1:0] fifo_mem [`FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr, rd_ptr;
  logic [CNT_W-1:0]       fifo_cnt;
  logic [`IPB_DATA_W-1:0] rd_mux;
  logic                   wr_hit, rd_start, rd_busy;
  logic                   push, pop;

  assign reg_op   = chan_reg_e'(io_addr);
  assign wr_hit   = chan_sel & io_wr_en;
  assign rd_start = chan_sel & io_rd_en & io_sync & ~rd_busy;   // first read cycle only
  assign push     = wr_hit & (reg_op == REG_FIFO) & (fifo_cnt != CNT_W'(`FIFO_DEPTH));
  assign pop      = rd_start & (reg_op == REG_FIFO) & (fifo_cnt != '0);

  assign chan_enable = ctrl_q[0];

  ////////////////////
  // writable registers
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q    <= '0;
      scratch_q <= '0;
    end else if (wr_hit) begin
      if (reg_op == REG_CTRL)    ctrl_q    <= io_wr_data;
      if (reg_op == REG_SCRATCH) scratch_q <= io_wr_data;
    end
  end

  ////////////////////
  // loopback FIFO, full push dropped and empty pop leaves count alone
  always_ff @(posedge ipb_clk) begin
    if (push) fifo_mem[wr_ptr] <= io_wr_data;
  end

  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push)     fifo_cnt <= fifo_cnt + 1'b1;    // never both in one cycle
      else if (pop) fifo_cnt <= fifo_cnt - 1'b1;
    end
  end

  ////////////////////
  // readback
  always_comb begin
    rd_mux = '0;                                    // unmapped offsets read zero
    case (reg_op)
      REG_CTRL:    rd_mux = ctrl_q;
      REG_SCRATCH: rd_mux = scratch_q;
      REG_FIFO:    if (fifo_cnt != '0) rd_mux = fifo_mem[rd_ptr];
      REG_LEVEL:   rd_mux[CNT_W-1:0] = fifo_cnt;
      REG_ID:      rd_mux = CHAN_ID[`IPB_DATA_W-1:0];
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_start) rd_data <= rd_mux;                // held for the arbiter
  end

  // one ack per read, rearmed once sync drops
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ack  <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      rd_ack <= rd_start;
      if (rd_start)      rd_busy <= 1'b1;
      else if (!io_sync) rd_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/ipb_io_interface.sv */
// IPbus wait-state controller
// turns the level strobe into sync, read enable and write enable pulses
// and answers the master with a one-cycle ipb_ack or ipb_err
`timescale 1ns/10ps
`default_nettype none

`include "chan_io_params.svh"

module ipb_io_interface (
  input  logic                   ipb_clk,
  input  logic                   arst_n,
  input  logic                   ipb_strobe,   // master holds this until ack or err
  input  logic                   ipb_write,    // write when high, read when low
  input  logic                   io_rd_ack,    // registered ack from the arbiter
  input  logic                   addr_bad,     // reserved channel field
  output logic                   io_sync,      // read outstanding
  output logic                   io_rd_en,     // high for the whole read
  output logic                   io_wr_en,     // single cycle write strobe
  output logic                   ipb_ack,
  output logic                   ipb_err,
  output chan_io_pkg::io_state_e state_peek    // for the debug pins
);

  import chan_io_pkg::*;

  localparam int TO_W = $clog2(`RD_TIMEOUT);

  io_state_e       state, next_state;
  logic [TO_W-1:0] to_cnt;                     // cycles spent in READ_WAIT
  logic            to_hit;

  assign to_hit = (to_cnt == TO_W'(`RD_TIMEOUT - 1));

  ////////////////////
  // state register
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // read timeout counter, restarts on every read
  always_ff @(posedge ipb_clk or negedge arst_n) begin
    if (!arst_n) begin
      to_cnt <= '0;
    end else if (state == READ_WAIT) begin
      to_cnt <= to_cnt + 1'b1;
    end else begin
      to_cnt <= '0;
    end
  end

  ////////////////////
  // next state
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (ipb_strobe) begin
          if (addr_bad)       next_state = ERR;         // nothing behind this field
          else if (ipb_write) next_state = WRITE;
          else                next_state = READ_START;
        end
      end
      WRITE:      next_state = WRITE_ACK;              // register takes data at this edge
      WRITE_ACK:  next_state = IDLE;
      READ_START: next_state = READ_WAIT;
      READ_WAIT: begin
        if (io_rd_ack)   next_state = READ_ACK;
        else if (to_hit) next_state = ERR;             // no channel answered
      end
      READ_ACK:   next_state = IDLE;
      ERR:        next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  // outputs decoded straight from the state register
  assign io_wr_en   = (state == WRITE);
  assign io_sync    = (state == READ_START) || (state == READ_WAIT);
  assign io_rd_en   = io_sync || (state == READ_ACK);
  assign ipb_ack    = (state == WRITE_ACK) || (state == READ_ACK);
  assign ipb_err    = (state == ERR);
  assign state_peek = state;

endmodule

`default_nettype wire

/* logic/chan_io_pkg.sv */
// shared types for the IPbus channel register side
// controller states and the register offset map of a channel
`default_nettype none

package chan_io_pkg;

  // wait-state controller states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,            // waiting for a strobe
    WRITE      = 3'd1,            // write enable out to the channels
    WRITE_ACK  = 3'd2,            // write done, ack to master
    READ_START = 3'd3,            // first read cycle, channel latches data
    READ_WAIT  = 3'd4,            // waiting on the arbiter's read ack
    READ_ACK   = 3'd5,            // read data on the bus, ack to master
    ERR        = 3'd6             // reserved channel or read timeout
  } io_state_e;

  // register offsets in address bits 3:0
  typedef enum logic [3:0] {
    REG_CTRL    = 4'd0,           // control, bit 0 is link enable
    REG_SCRATCH = 4'd1,           // free read/write word
    REG_FIFO    = 4'd2,           // write pushes, read pops
    REG_LEVEL   = 4'd3,           // FIFO fill level, read only
    REG_ID      = 4'd4            // channel number, read only
  } chan_reg_e;

endpackage

`default_nettype wire

/* logic/chan_io_params.svh */
// channel register side of the serial-link board
// bus widths, channel count and controller limits
`ifndef CHAN_IO_PARAMS_SVH
`define CHAN_IO_PARAMS_SVH

// IPbus widths
`define IPB_ADDR_W    24        // slave address width
`define IPB_DATA_W    32        // read and write data width

// channel space
`define NUM_CHAN      4         // channel blocks, field values above are reserved
`define CHAN_SEL_LSB  20        // bottom bit of the 4-bit channel field

// per channel resources and controller limits
`define FIFO_DEPTH    4         // loopback FIFO entries
`define RD_TIMEOUT    16        // read wait cycles before ipb_err

`endif
